//--- soc_pkg.sv
// Package: bus word and address types, address map, mux select, sample widths, register offsets
`default_nettype none

package soc_pkg;

  // ****************************************
  // Bus types
  // ****************************************

  // One AHB data word
  typedef logic [31:0] ahb_word_t;

  // Address seen either flat or as region plus offset
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [3:0]  region;
      logic [27:0] offset;
    } f;
  } ahb_addr_t;

  // Address map, top nibble
  localparam logic [3:0] REGION_SRAM   = 4'h0;
  localparam logic [3:0] REGION_GPIO   = 4'h4;
  localparam logic [3:0] REGION_SAMPLE = 4'h5;

  // Read mux select, NOMAP doubles as default slave
  typedef enum logic [1:0] {
    MUX_SRAM,
    MUX_GPIO,
    MUX_SAMPLE,
    MUX_NOMAP
  } mux_sel_t;

  typedef logic [3:0] led_t;

  // ****************************************
  // Sample chain
  // ****************************************

  localparam int ADC_W    = 12;
  localparam int CHAN_W   = 2;
  localparam int SEQ_W    = 12;
  // Entry packs channel, sequence, value from msb down
  localparam int SAMPLE_W = CHAN_W + SEQ_W + ADC_W;

  // Sample port registers
  localparam logic [7:0] SP_DATA   = 8'h00;
  localparam logic [7:0] SP_STATUS = 8'h04;

endpackage

`default_nettype wire

//--- ahb_decoder.sv
// Module ahb_decoder: region decode into slave selects and read mux select
`default_nettype none

module ahb_decoder import soc_pkg::*; (
  input  ahb_addr_t haddr,
  output logic      hsel_sram,
  output logic      hsel_gpio,
  output logic      hsel_sample,
  output logic      hsel_nomap,
  output mux_sel_t  mux_sel
);

  // One-hot select from the top nibble
  always_comb begin
    hsel_sram   = 1'b0;
    hsel_gpio   = 1'b0;
    hsel_sample = 1'b0;
    hsel_nomap  = 1'b0;
    mux_sel     = MUX_NOMAP;
    case (haddr.f.region)
      REGION_SRAM: begin
        hsel_sram = 1'b1;
        mux_sel   = MUX_SRAM;
      end
      REGION_GPIO: begin
        hsel_gpio = 1'b1;
        mux_sel   = MUX_GPIO;
      end
      REGION_SAMPLE: begin
        hsel_sample = 1'b1;
        mux_sel     = MUX_SAMPLE;
      end
      // Anything else falls to the default slave
      default: hsel_nomap = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- ahb_read_mux.sv
// Module ahb_read_mux: data-phase select register, hrdata/hready mux, default slave
`default_nettype none

module ahb_read_mux import soc_pkg::*; (
  input  logic       fclk,
  input  logic       resetn,
  input  logic [1:0] htrans,
  input  logic       hready_in,
  input  mux_sel_t   mux_sel,
  input  ahb_word_t  hrdata_sram,
  input  ahb_word_t  hrdata_gpio,
  input  ahb_word_t  hrdata_sample,
  input  logic       hreadyout_sram,
  input  logic       hreadyout_gpio,
  input  logic       hreadyout_sample,
  output ahb_word_t  hrdata,
  output logic       hready
);

  // Select of the transfer now in its data phase
  mux_sel_t sel_q;

  // Idle address phases park on the default slave
  always_ff @(posedge fclk or negedge resetn) begin
    if (!resetn) begin
      sel_q <= MUX_NOMAP;
    end else if (hready_in) begin
      sel_q <= htrans[1] ? mux_sel : MUX_NOMAP;
    end
  end

  always_comb begin
    // Default slave: zero data, always ready
    hrdata = '0;
    hready = 1'b1;
    case (sel_q)
      MUX_SRAM: begin
        hrdata = hrdata_sram;
        hready = hreadyout_sram;
      end
      MUX_GPIO: begin
        hrdata = hrdata_gpio;
        hready = hreadyout_gpio;
      end
      MUX_SAMPLE: begin
        hrdata = hrdata_sample;
        hready = hreadyout_sample;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

//--- ahb_sram.sv
// Module ahb_sram: zero-wait AHB-Lite SRAM slave with byte lane writes
`default_nettype none

module ahb_sram import soc_pkg::*; #(
  parameter int SRAM_WORDS = 256
) (
  input  logic       fclk,
  input  logic       resetn,
  input  logic       hsel,
  input  ahb_addr_t  haddr,
  input  logic [1:0] htrans,
  input  logic       hwrite,
  input  logic [2:0] hsize,
  input  ahb_word_t  hwdata,
  input  logic       hready,
  output ahb_word_t  hrdata,
  output logic       hreadyout
);

  localparam int IDX_W = (SRAM_WORDS > 1) ? $clog2(SRAM_WORDS) : 1;

  ahb_word_t        mem [SRAM_WORDS];
  logic             accept;
  logic [29:0]      word_addr;
  logic [IDX_W-1:0] idx_d;
  logic [IDX_W-1:0] idx_q;
  logic [3:0]       be_d;
  logic [3:0]       be_q;
  logic             wr_q;

  // ****************************************
  // Address phase
  // ****************************************

  assign accept    = hsel & hready & htrans[1];
  assign word_addr = haddr.raw[31:2];
  // Word index wraps on the array size
  assign idx_d     = IDX_W'(word_addr % SRAM_WORDS);

  // Byte lanes from size and low address bits
  always_comb begin
    case (hsize)
      3'b000:  be_d = 4'b0001 << haddr.raw[1:0];
      3'b001:  be_d = haddr.raw[1] ? 4'b1100 : 4'b0011;
      default: be_d = 4'b1111;
    endcase
  end

  always_ff @(posedge fclk or negedge resetn) begin
    if (!resetn) begin
      wr_q <= 1'b0;
    end else if (hready) begin
      wr_q <= accept & hwrite;
    end
  end

  // ****************************************
  // Data phase
  // ****************************************

  always_ff @(posedge fclk) begin
    if (accept) begin
      idx_q <= idx_d;
      be_q  <= be_d;
    end
    // Only enabled lanes are touched
    if (wr_q) begin
      for (int i = 0; i < 4; i++) begin
        if (be_q[i]) begin
          mem[idx_q][8*i +: 8] <= hwdata[8*i +: 8];
        end
      end
    end
  end

  // Read straight from the array, sees a write one cycle back
  assign hrdata    = mem[idx_q];
  assign hreadyout = 1'b1;

endmodule

`default_nettype wire

//--- ahb_gpio.sv
// Module ahb_gpio: AHB-Lite LED register slave
`default_nettype none

module ahb_gpio import soc_pkg::*; (
  input  logic       fclk,
  input  logic       resetn,
  input  logic       hsel,
  input  ahb_addr_t  haddr,
  input  logic [1:0] htrans,
  input  logic       hwrite,
  input  ahb_word_t  hwdata,
  input  logic       hready,
  output ahb_word_t  hrdata,
  output logic       hreadyout,
  output led_t       led
);

  logic accept;
  logic hit;
  logic hit_q;
  logic wr_q;

  // LED register lives at offset 0 only
  assign accept = hsel & hready & htrans[1];
  assign hit    = (haddr.raw[27:0] == 28'h0);

  always_ff @(posedge fclk or negedge resetn) begin
    if (!resetn) begin
      hit_q <= 1'b0;
      wr_q  <= 1'b0;
      led   <= '0;
    end else begin
      if (hready) begin
        hit_q <= accept & hit;
        wr_q  <= accept & hit & hwrite;
      end
      // Write data lands in the data phase
      if (wr_q) begin
        led <= hwdata[3:0];
      end
    end
  end

  // Zero-extended readback
  assign hrdata    = hit_q ? {28'h0, led} : '0;
  assign hreadyout = 1'b1;

endmodule

`default_nettype wire

//--- sensor_sampler.sv
// Module sensor_sampler: ADC strobe capture into tagged sample entries
`default_nettype none

module sensor_sampler import soc_pkg::*; (
  input  logic                fclk,
  input  logic                resetn,
  input  logic                adc_strobe,
  input  logic [CHAN_W-1:0]   adc_channel,
  input  logic [ADC_W-1:0]    adc_value,
  output logic                push,
  output logic [SAMPLE_W-1:0] push_entry
);

  // Free-running tag, counts dropped samples too
  logic [SEQ_W-1:0] seq;

  // ****************************************
  // Push strobe and sequence
  // ****************************************

  always_ff @(posedge fclk or negedge resetn) begin
    if (!resetn) begin
      push <= 1'b0;
      seq  <= '0;
    end else begin
      // One cycle behind the strobe
      push <= adc_strobe;
      if (adc_strobe) begin
        seq <= seq + 1'b1;
      end
    end
  end

  // Entry is channel, sequence, value
  always_ff @(posedge fclk) begin
    if (adc_strobe) begin
      push_entry <= {adc_channel, seq, adc_value};
    end
  end

endmodule

`default_nettype wire

//--- sample_fifo.sv
// Module sample_fifo: sample buffer FIFO with level, sticky overflow and drop counter
`default_nettype none

module sample_fifo import soc_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                fclk,
  input  logic                resetn,
  input  logic                push,
  input  logic [SAMPLE_W-1:0] push_entry,
  input  logic                pop,
  input  logic                clear,
  output logic [SAMPLE_W-1:0] pop_entry,
  output logic                empty,
  output logic [7:0]          level,
  output logic                overflow,
  output logic [7:0]          drop_count
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  logic [SAMPLE_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CNT_W-1:0]    count;
  logic                full;
  logic                do_push;
  logic                do_pop;
  logic                dropped;

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(FIFO_DEPTH));
  assign do_pop  = pop & ~empty;
  // A pop frees the slot for a push on a full FIFO
  assign do_push = push & (~full | do_pop);
  assign dropped = push & ~do_push;

  always_ff @(posedge fclk or negedge resetn) begin
    if (!resetn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      overflow   <= 1'b0;
      drop_count <= '0;
    end else begin
      // Pointers wrap on the power-of-two depth
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
      count <= count + CNT_W'(do_push) - CNT_W'(do_pop);
      // A drop wins over a clear in the same cycle
      if (dropped) begin
        overflow <= 1'b1;
        if (clear) drop_count <= 8'd1;
        else if (drop_count != 8'hff) drop_count <= drop_count + 8'd1;
      end else if (clear) begin
        overflow   <= 1'b0;
        drop_count <= '0;
      end
    end
  end

  always_ff @(posedge fclk) begin
    if (do_push) mem[wr_ptr] <= push_entry;
  end

  // Head entry, valid whenever not empty
  assign pop_entry = mem[rd_ptr];
  assign level     = 8'(count);

endmodule

`default_nettype wire

//--- ahb_sample_port.sv
// Module ahb_sample_port: AHB-Lite slave popping samples and reporting FIFO status
`default_nettype none

module ahb_sample_port import soc_pkg::*; (
  input  logic                fclk,
  input  logic                resetn,
  input  logic                hsel,
  input  ahb_addr_t           haddr,
  input  logic [1:0]          htrans,
  input  logic                hwrite,
  input  ahb_word_t           hwdata,
  input  logic                hready,
  input  logic [SAMPLE_W-1:0] pop_entry,
  input  logic                empty,
  input  logic [7:0]          level,
  input  logic                overflow,
  input  logic [7:0]          drop_count,
  output ahb_word_t           hrdata,
  output logic                hreadyout,
  output logic                pop,
  output logic                clear
);

  logic      accept;
  logic      rd_data;
  logic      rd_status;
  logic      wr_status;
  logic      wr_status_q;
  ahb_word_t rdata_d;
  ahb_word_t rdata_q;

  // ****************************************
  // Address phase decode
  // ****************************************

  assign accept    = hsel & hready & htrans[1];
  assign rd_data   = accept & ~hwrite & (haddr.raw[7:0] == SP_DATA);
  assign rd_status = accept & ~hwrite & (haddr.raw[7:0] == SP_STATUS);
  assign wr_status = accept & hwrite & (haddr.raw[7:0] == SP_STATUS);
  // Pop in the address phase, never on empty
  assign pop       = rd_data & ~empty;

  // Read word built now, returned next cycle
  always_comb begin
    rdata_d = '0;
    if (pop) begin
      rdata_d[31]            = 1'b1;
      rdata_d[28 +: CHAN_W]  = pop_entry[SAMPLE_W-1 -: CHAN_W];
      rdata_d[16 +: SEQ_W]   = pop_entry[ADC_W +: SEQ_W];
      rdata_d[0 +: ADC_W]    = pop_entry[ADC_W-1:0];
    end else if (rd_status) begin
      rdata_d[31]    = overflow;
      rdata_d[23:16] = drop_count;
      rdata_d[7:0]   = level;
    end
  end

  always_ff @(posedge fclk) begin
    if (accept) rdata_q <= rdata_d;
  end

  always_ff @(posedge fclk or negedge resetn) begin
    if (!resetn) begin
      wr_status_q <= 1'b0;
    end else if (hready) begin
      wr_status_q <= wr_status;
    end
  end

  // Clear pulse needs write data, so data phase
  assign clear     = wr_status_q & hwdata[31];
  assign hrdata    = rdata_q;
  assign hreadyout = 1'b1;

endmodule

`default_nettype wire

//--- agri_subsys.sv
// Module agri_subsys: AHB-Lite bus fabric, SRAM, GPIO and sensor sample chain
`default_nettype none

module agri_subsys import soc_pkg::*; #(
  parameter int SRAM_WORDS = 256,
  parameter int FIFO_DEPTH = 8
) (
  input  logic              fclk,
  input  logic              resetn,
  // AHB-Lite master side
  input  ahb_addr_t         haddr,
  input  logic [1:0]        htrans,
  input  logic              hwrite,
  input  logic [2:0]        hsize,
  input  ahb_word_t         hwdata,
  output ahb_word_t         hrdata,
  output logic              hready,
  // ADC strobe side
  input  logic              adc_strobe,
  input  logic [CHAN_W-1:0] adc_channel,
  input  logic [ADC_W-1:0]  adc_value,
  output led_t              led
);

  logic                hsel_sram;
  logic                hsel_gpio;
  logic                hsel_sample;
  mux_sel_t            mux_sel;
  ahb_word_t           hrdata_sram;
  ahb_word_t           hrdata_gpio;
  ahb_word_t           hrdata_sample;
  logic                hreadyout_sram;
  logic                hreadyout_gpio;
  logic                hreadyout_sample;
  logic                push;
  logic [SAMPLE_W-1:0] push_entry;
  logic                pop;
  logic                clear;
  logic [SAMPLE_W-1:0] pop_entry;
  logic                empty;
  logic [7:0]          level;
  logic                overflow;
  logic [7:0]          drop_count;

  // ****************************************
  // Bus fabric
  // ****************************************

  // Unmapped accesses are answered inside the read mux
  ahb_decoder u_decoder (
    .haddr(haddr), .hsel_sram(hsel_sram), .hsel_gpio(hsel_gpio),
    .hsel_sample(hsel_sample), .hsel_nomap(), .mux_sel(mux_sel)
  );

  ahb_read_mux u_read_mux (
    .fclk(fclk), .resetn(resetn), .htrans(htrans), .hready_in(hready),
    .mux_sel(mux_sel), .hrdata_sram(hrdata_sram), .hrdata_gpio(hrdata_gpio),
    .hrdata_sample(hrdata_sample), .hreadyout_sram(hreadyout_sram),
    .hreadyout_gpio(hreadyout_gpio), .hreadyout_sample(hreadyout_sample),
    .hrdata(hrdata), .hready(hready)
  );

  // ****************************************
  // Slaves
  // ****************************************

  ahb_sram #(.SRAM_WORDS(SRAM_WORDS)) u_sram (
    .fclk(fclk), .resetn(resetn), .hsel(hsel_sram), .haddr(haddr),
    .htrans(htrans), .hwrite(hwrite), .hsize(hsize), .hwdata(hwdata),
    .hready(hready), .hrdata(hrdata_sram), .hreadyout(hreadyout_sram)
  );

  ahb_gpio u_gpio (
    .fclk(fclk), .resetn(resetn), .hsel(hsel_gpio), .haddr(haddr),
    .htrans(htrans), .hwrite(hwrite), .hwdata(hwdata), .hready(hready),
    .hrdata(hrdata_gpio), .hreadyout(hreadyout_gpio), .led(led)
  );

  ahb_sample_port u_sample_port (
    .fclk(fclk), .resetn(resetn), .hsel(hsel_sample), .haddr(haddr),
    .htrans(htrans), .hwrite(hwrite), .hwdata(hwdata), .hready(hready),
    .pop_entry(pop_entry), .empty(empty), .level(level), .overflow(overflow),
    .drop_count(drop_count), .hrdata(hrdata_sample),
    .hreadyout(hreadyout_sample), .pop(pop), .clear(clear)
  );

  // Producer into buffer, drained by the sample port
  sensor_sampler u_sampler (
    .fclk(fclk), .resetn(resetn), .adc_strobe(adc_strobe),
    .adc_channel(adc_channel), .adc_value(adc_value),
    .push(push), .push_entry(push_entry)
  );

  sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .fclk(fclk), .resetn(resetn), .push(push), .push_entry(push_entry),
    .pop(pop), .clear(clear), .pop_entry(pop_entry), .empty(empty),
    .level(level), .overflow(overflow), .drop_count(drop_count)
  );

endmodule

`default_nettype wire

//--- tb_agri_subsys.sv
// Testbench tb_agri_subsys: pattern-driven AHB-Lite and ADC stimulus, hrdata and LED compare tasks
`default_nettype none

module tb_agri_subsys import soc_pkg::*; ();

  localparam int SRAM_WORDS = 256;
  localparam int FIFO_DEPTH = 8;
  // Record is op, size, addr, data, expected
  localparam int REC_W      = 104;
  localparam int MAX_RECS   = 64;
  localparam int TIMEOUT    = 100;

  logic              fclk;
  logic              resetn;
  ahb_addr_t         haddr;
  logic [1:0]        htrans;
  logic              hwrite;
  logic [2:0]        hsize;
  ahb_word_t         hwdata;
  ahb_word_t         hrdata;
  logic              hready;
  logic              adc_strobe;
  logic [CHAN_W-1:0] adc_channel;
  logic [ADC_W-1:0]  adc_value;
  led_t              led;

  logic [REC_W-1:0]  patterns [MAX_RECS];
  int                word_errors;
  int                led_errors;
  int                timeout_errors;
  int                record_errors;

  agri_subsys #(.SRAM_WORDS(SRAM_WORDS), .FIFO_DEPTH(FIFO_DEPTH)) DUT (
    .fclk(fclk), .resetn(resetn), .haddr(haddr), .htrans(htrans),
    .hwrite(hwrite), .hsize(hsize), .hwdata(hwdata), .hrdata(hrdata),
    .hready(hready), .adc_strobe(adc_strobe), .adc_channel(adc_channel),
    .adc_value(adc_value), .led(led)
  );

  initial begin
    fclk = 1'b0;
    forever #4 fclk = ~fclk;
  end

  // ****************************************
  // Compare tasks
  // ****************************************

  task automatic check_word(input ahb_word_t got, input ahb_word_t exp);
    if (got !== exp) begin
      $display("[FAIL] hrdata got %h expected %h at %0t", got, exp, $time);
      word_errors++;
    end
  endtask

  task automatic check_led(input led_t got, input led_t exp);
    if (got !== exp) begin
      $display("[FAIL] led got %h expected %h at %0t", got, exp, $time);
      led_errors++;
    end
  endtask

  // ****************************************
  // AHB master tasks
  // ****************************************

  // Polls at falling edges until the next rising edge can complete the phase
  task automatic wait_ready(input string phase);
    int cycles;
    cycles = 0;
    while (hready !== 1'b1 && cycles <= TIMEOUT) begin
      @(negedge fclk);
      cycles++;
    end
    if (hready !== 1'b1) begin
      $display("Timeout: hready stayed low in the %s", phase);
      timeout_errors++;
    end
  endtask

  task automatic drive_addr(input logic wr, input logic [2:0] size, input ahb_word_t addr);
    haddr.raw = addr;
    htrans    = 2'b10;
    hwrite    = wr;
    hsize     = size;
  endtask

  task automatic drive_idle();
    htrans = 2'b00;
    hwrite = 1'b0;
  endtask

  // One NONSEQ transfer with an idle bus around it
  task automatic ahb_single(input logic wr, input logic [2:0] size, input ahb_word_t addr,
                            input ahb_word_t wdata, input ahb_word_t exp);
    drive_addr(wr, size, addr);
    wait_ready("address phase");
    @(negedge fclk);
    drive_idle();
    hwdata = wdata;
    wait_ready("data phase");
    if (!wr) check_word(hrdata, exp);
    @(negedge fclk);
  endtask

  // Records first..last back to back with each data phase under the next address
  task automatic ahb_pipelined(input int first, input int last);
    logic [REC_W-1:0] rec;
    logic [REC_W-1:0] prev;
    for (int i = first; i <= last + 1; i++) begin
      if (i <= last) begin
        rec = patterns[i];
        drive_addr(rec[102:100] == 3'd1, rec[98:96], rec[95:64]);
      end else begin
        drive_idle();
      end
      if (i > first) begin
        prev   = patterns[i-1];
        hwdata = prev[63:32];
      end
      wait_ready("pipelined transfer");
      if (i > first && prev[102:100] == 3'd2) check_word(hrdata, prev[31:0]);
      @(negedge fclk);
    end
  endtask

  // ****************************************
  // ADC side
  // ****************************************

  // Strobe and a settle cycle for push before a random gap
  task automatic strobe_adc(input logic [CHAN_W-1:0] chan, input logic [ADC_W-1:0] value);
    int gap;
    adc_channel = chan;
    adc_value   = value;
    adc_strobe  = 1'b1;
    @(negedge fclk);
    adc_strobe = 1'b0;
    @(negedge fclk);
    gap = $urandom % 4;
    repeat (gap) @(negedge fclk);
  endtask

  // ****************************************
  // Pattern runner
  // ****************************************

  initial begin
    int               i;
    int               last;
    int               n;
    logic [REC_W-1:0] rec;
    void'($urandom(32'ha08b));
    resetn         = 1'b0;
    haddr.raw      = '0;
    htrans         = 2'b00;
    hwrite         = 1'b0;
    hsize          = 3'b010;
    hwdata         = '0;
    adc_strobe     = 1'b0;
    adc_channel    = '0;
    adc_value      = '0;
    word_errors    = 0;
    led_errors     = 0;
    timeout_errors = 0;
    record_errors  = 0;
    $readmemh("agri_patterns.hex", patterns);
    repeat (5) @(negedge fclk);
    resetn = 1'b1;
    @(negedge fclk);
    i = 0;
    while (i < MAX_RECS && !$isunknown(patterns[i])) begin
      rec = patterns[i];
      // data[31:24] is the repeat count for strobes and reads where zero means once
      n = (rec[63:56] == 8'd0) ? 1 : int'(rec[63:56]);
      case (rec[102:100])
        3'd0: repeat (rec[63:32]) @(negedge fclk);
        3'd1, 3'd2: begin
          if (rec[103]) begin
            last = i;
            while (last + 1 < MAX_RECS && patterns[last][103] === 1'b1) last++;
            ahb_pipelined(i, last);
            i = last;
          end else if (rec[102:100] == 3'd1) begin
            ahb_single(1'b1, rec[98:96], rec[95:64], rec[63:32], '0);
          end else begin
            // Expected steps by data[23:0] per repeat
            for (int k = 0; k < n; k++) begin
              ahb_single(1'b0, rec[98:96], rec[95:64], '0,
                         ahb_word_t'(rec[31:0] + k * rec[55:32]));
            end
          end
        end
        3'd3: begin
          for (int k = 0; k < n; k++) begin
            strobe_adc(rec[64 +: CHAN_W], rec[32 +: ADC_W] + ADC_W'(k));
          end
        end
        3'd4: check_led(led, rec[3:0]);
        default: begin
          $display("Unknown opcode in pattern record %0d", i);
          record_errors++;
        end
      endcase
      i++;
    end
    $display("Error counts: hrdata %0d, led %0d, timeouts %0d, bad records %0d",
             word_errors, led_errors, timeout_errors, record_errors);
    if (word_errors + led_errors + timeout_errors + record_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- agri_patterns.hex
// op[3] pipelined with next, op[2:0] 0 idle 1 write 2 read-check 3 adc strobe 4 led check
// op size addr data expected; data[31:24] repeats reads and strobes, addr is adc channel
0_0_00000000_00000002_00000000
1_2_00000010_a5a5a5a5_00000000
1_0_00000011_00003c00_00000000
1_1_00000012_77770000_00000000
2_2_00000010_00000000_77773ca5
9_2_00000020_12345678_00000000
2_2_00000020_00000000_12345678
1_2_40000000_123456a5_00000000
4_0_00000000_00000000_00000005
2_2_40000000_00000000_00000005
3_0_00000003_0b000100_00000000
2_2_50000004_00000000_80030008
1_2_50000004_80000000_00000000
2_2_50000004_00000000_00000008
2_2_50000000_08010001_b0000100
2_2_50000000_00000000_00000000
3_0_00000001_00000abc_00000000
3_0_00000002_00000123_00000000
2_2_50000000_00000000_900b0abc
2_2_50000000_00000000_a00c0123
2_2_80000000_00000000_00000000
1_2_80000010_deadbeef_00000000
2_2_00000010_00000000_77773ca5
4_0_00000000_00000000_00000005
9_2_40000000_00000003_00000000
a_2_00000020_00000000_12345678
a_2_40000000_00000000_00000003
2_2_00000010_00000000_77773ca5
4_0_00000000_00000000_00000003

//--- project.f
soc_pkg.sv
ahb_decoder.sv
ahb_read_mux.sv
ahb_sram.sv
ahb_gpio.sv
sensor_sampler.sv
sample_fifo.sv
ahb_sample_port.sv
agri_subsys.sv
tb_agri_subsys.sv

//--- Bender.yml
package:
  name: agri_subsys

sources:
  - soc_pkg.sv
  - ahb_decoder.sv
  - ahb_read_mux.sv
  - ahb_sram.sv
  - ahb_gpio.sv
  - sensor_sampler.sv
  - sample_fifo.sv
  - ahb_sample_port.sv
  - agri_subsys.sv
  - target: test
    files:
      - tb_agri_subsys.sv
